// File: filelist.f
+incdir+.
ilk_status_pkg.sv
ilk_lane_framer.sv
ilk_lane_status_monitor.sv
ilk_status_event_reporter.sv
ilk_rx_status_top.sv
ilk_rx_status_properties.sv
ilk_rx_status_tb.sv

// File: Makefile
SIM := obj_dir/Vilk_rx_status_tb

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -f filelist.f \
		--top-module ilk_rx_status_tb -o Vilk_rx_status_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ilk_rx_status_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the rx lane status top, four lane clocks and a host
// lane words follow a reference framer model, records are summed
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_rx_status_tb
	import ilk_status_pkg::*;
;

localparam int NL = `ILK_NUM_LANES;

// reference framer state for one lane, errs is indexed by err_kind_e
typedef struct packed {
	logic        wlk;
	logic [3:0]  gcnt;
	logic [2:0]  bcnt;
	lock_state_e smode;
	logic [3:0]  pos;
	logic [2:0]  scnt;
	logic [3:0]  errs;
} ref_state_t;

logic common_clk = 1'b0;
logic common_arst = 1'b1;
logic [NL-1:0] lane_arst = '1;
logic ev_credit = 1'b0;
wire [NL-1:0] lane_clk;
wire lane_word_t [NL-1:0] lane_in;
logic ev_valid;
status_event_t ev;
logic all_word_locked;
logic all_sync_locked;
wire [NL-1:0][`ILK_CRC_CNT_W-1:0] crc_err_cnt;

// 0 clean, 1 random errors, 2 crc burst, 3 sync drop on lane 0, 4 clean
int phase = 0;
logic hold = 1'b0;
int outstanding = 0;
int ev_sum [NL][4] = '{default: 0};
bit ev_sat [NL][4] = '{default: 1'b0};
logic [31:0] host_rng = 32'hd3d0 ^ 32'h55;
wire [31:0] exp_flat [NL][4];

ilk_rx_status_top dut0 (
	.common_clk      (common_clk),
	.common_arst     (common_arst),
	.lane_clk        (lane_clk),
	.lane_arst       (lane_arst),
	.lane_in         (lane_in),
	.ev_credit       (ev_credit),
	.ev_valid        (ev_valid),
	.ev              (ev),
	.all_word_locked (all_word_locked),
	.all_sync_locked (all_sync_locked),
	.crc_err_cnt     (crc_err_cnt)
);

bind ilk_status_event_reporter ilk_rx_status_properties rep_props (
	.common_clk (common_clk), .common_arst (common_arst), .ev_credit (ev_credit),
	.ev_valid (ev_valid), .ev (ev), .all_word_locked (1'b0), .all_sync_locked (1'b0)
);
bind ilk_rx_status_top ilk_rx_status_properties top_props (
	.common_clk (common_clk), .common_arst (common_arst), .ev_credit (ev_credit),
	.ev_valid (ev_valid), .ev (ev),
	.all_word_locked (all_word_locked), .all_sync_locked (all_sync_locked)
);

always #20 common_clk = ~common_clk;

function automatic logic [31:0] xorshift(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// one word through the framer rules, pulses use the state before the word
function automatic ref_state_t ref_step(input ref_state_t s, input lane_word_t w);
	ref_state_t n;
	logic good;
	logic slk;
	n = s;
	good = (w.kind != BAD_HDR);
	slk = s.wlk && (s.smode == LOCKED);
	n.errs = '0;
	n.errs[ERR_FRAMING] = s.wlk && !good;
	n.errs[ERR_CRC32] = slk && (w.kind == DIAG) && !w.crc_ok;
	n.errs[ERR_SCRAMBLER] = slk && (w.kind == SCRAM) && !w.scram_ok;
	if (!s.wlk) begin
		n.gcnt = good ? s.gcnt + 4'd1 : 4'd0;
		if (n.gcnt == 4'(`ILK_WORD_LOCK_GOOD)) begin
			n.wlk = 1'b1;
			n.bcnt = '0;
		end
	end else begin
		n.bcnt = good ? 3'd0 : s.bcnt + 3'd1;
		if (n.bcnt == 3'(`ILK_WORD_LOCK_BAD)) begin
			n.wlk = 1'b0;
			n.gcnt = '0;
		end
	end
	if (!s.wlk) begin
		n.smode = HUNT;
		n.scnt = '0;
		n.pos = '0;
	end else begin
		// 4 bit position wraps at the metaframe length
		n.pos = s.pos + 4'd1;
		case (s.smode)
			HUNT: begin
				if (w.kind == SYNC) begin
					n.smode = LOCKING;
					n.scnt = 3'd1;
					n.pos = 4'd1;
				end
			end
			LOCKING: begin
				if (s.pos == 4'd0) begin
					if (w.kind != SYNC) begin
						n.smode = HUNT;
						n.scnt = '0;
					end else begin
						n.scnt = s.scnt + 3'd1;
						if (n.scnt == 3'(`ILK_SYNC_LOCK_GOOD)) begin
							n.smode = LOCKED;
							n.scnt = '0;
						end
					end
				end else if (w.kind == SYNC) begin
					n.scnt = 3'd1;
					n.pos = 4'd1;
				end
			end
			default: begin
				// locked, scnt counts misses in a row
				if (s.pos == 4'd0) begin
					if (w.kind == SYNC) begin
						n.scnt = '0;
					end else begin
						n.errs[ERR_MISSING_SYNC] = 1'b1;
						n.scnt = s.scnt + 3'd1;
						if (n.scnt == 3'(`ILK_SYNC_LOCK_MISS)) begin
							n.smode = HUNT;
							n.scnt = '0;
						end
					end
				end
			end
		endcase
	end
	return n;
endfunction

for (genvar g = 0; g < NL; g++) begin : g_lane
	logic clk = 1'b0;
	lane_word_t word = '0;
	ref_state_t st = '0;
	int p = 0;
	int drops = 0;
	int exp_cnt [4] = '{default: 0};
	logic [31:0] rng = 32'hd3d0 ^ 32'(g);

	// 36, 44, 52 and 60 ns
	always #(18 + 4 * g) clk = ~clk;
	assign lane_clk[g] = clk;
	assign lane_in[g] = word;
	for (genvar k = 0; k < 4; k++) begin : g_exp
		assign exp_flat[g][k] = exp_cnt[k];
	end

	always @(negedge clk) begin
		lane_word_t w;
		if (!lane_arst[g]) begin
			rng = xorshift(rng);
			w = '0;
			w.valid = 1'b1;
			w.kind = DATA;
			w.crc_ok = 1'b1;
			w.scram_ok = 1'b1;
			if (p == 0) begin
				if (g == 0 && phase == 3 && drops < `ILK_SYNC_LOCK_MISS) begin
					drops = drops + 1;
				end else begin
					w.kind = SYNC;
				end
			end else if (phase == 2) begin
				// every other word, so no two toggles land in one common cycle
				if (p % 2 == 1) begin
					w.kind = DIAG;
					w.crc_ok = 1'b0;
				end
			end else if (p == 3 && phase == 1 && rng[1:0] == 2'b00) begin
				w.kind = BAD_HDR;
			end else if (p == 5) begin
				w.kind = DIAG;
				w.crc_ok = (phase == 1) ? rng[2] : 1'b1;
			end else if (p == 9) begin
				w.kind = SCRAM;
				w.scram_ok = (phase == 1) ? (rng[3] | rng[4]) : 1'b1;
			end
			st = ref_step(st, w);
			for (int k = 0; k < 4; k++) begin
				exp_cnt[k] = exp_cnt[k] + (st.errs[k] ? 1 : 0);
			end
			word = w;
			p = (p + 1) % `ILK_MFRAME_LEN;
		end
	end
end

task automatic fail_now(input string why);
	$display("%s", why);
	$display("Simulation finished: FAIL");
	$fatal(1, "stopped on first error");
endtask

task automatic check_event(input string name, input status_event_t got,
	input status_event_t exp);
	if (got !== exp) begin
		fail_now($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
	end
endtask

task automatic check_count(input string name, input logic [`ILK_CRC_CNT_W-1:0] got,
	input logic [`ILK_CRC_CNT_W-1:0] exp);
	if (got !== exp) begin
		fail_now($sformatf("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp));
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		fail_now($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
	end
endtask

task automatic check_total(input string name, input int got, input int exp);
	if (got != exp) begin
		fail_now($sformatf("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp));
	end
endtask

// host side, a record seen here is taken at the next rising edge
always @(negedge common_clk) begin
	int remain;
	status_event_t exp_ev;
	if (!common_arst && ev_valid) begin
		if (outstanding >= `ILK_EVENT_CREDITS) begin
			fail_now("event record sent while every credit was outstanding");
		end
		// a record never claims more than the lane side has produced
		remain = int'(exp_flat[ev.lane][ev.kind]) - ev_sum[ev.lane][ev.kind];
		exp_ev = ev;
		if (int'(ev.count) > remain || ev.count == 4'd0) begin
			exp_ev.count = 4'(remain);
		end
		check_event("ev", ev, exp_ev);
		ev_sum[ev.lane][ev.kind] = ev_sum[ev.lane][ev.kind] + int'(ev.count);
		if (ev.count == 4'hf) begin
			ev_sat[ev.lane][ev.kind] = 1'b1;
		end
		outstanding = outstanding + 1;
	end
	// credits go back at random unless the host holds them
	host_rng = xorshift(host_rng);
	ev_credit = !hold && (outstanding > 0) && (host_rng[1:0] != 2'b00);
	if (ev_credit) begin
		outstanding = outstanding - 1;
	end
end

task automatic run_cycles(input int n);
	for (int i = 0; i < n; i++) begin
		@(negedge common_clk);
	end
endtask

// which 0 is all_word_locked, 1 is all_sync_locked
task automatic wait_flag(input string what, input int which, input logic level);
	int n;
	n = 0;
	while (((which == 0) ? all_word_locked : all_sync_locked) !== level) begin
		@(negedge common_clk);
		n++;
		if (n > 4000) begin
			fail_now($sformatf("timeout waiting for %s", what));
		end
	end
endtask

task automatic wait_drain();
	int quiet;
	int n;
	quiet = 0;
	n = 0;
	while (quiet < 64) begin
		@(negedge common_clk);
		n++;
		quiet = (outstanding == 0 && !ev_valid) ? quiet + 1 : 0;
		if (n > 20000) begin
			fail_now("timeout waiting for event records to drain");
		end
	end
endtask

initial begin
	repeat (16) @(posedge common_clk);
	@(negedge common_clk);
	common_arst = 1'b0;
	lane_arst = '0;
	@(negedge common_clk);
	check_flag("all_word_locked", all_word_locked, 1'b0);
	check_flag("all_sync_locked", all_sync_locked, 1'b0);
	check_flag("ev_valid", ev_valid, 1'b0);

	// lock on clean metaframes, word lock comes first
	wait_flag("word lock on all lanes", 0, 1'b1);
	check_flag("all_sync_locked", all_sync_locked, 1'b0);
	wait_flag("sync lock on all lanes", 1, 1'b1);

	// random errors, first with credits held back
	phase = 1;
	hold = 1'b1;
	run_cycles(300);
	// every credit spent, later errors wait merged in the reporter
	check_total("records outstanding with credits held", outstanding, `ILK_EVENT_CREDITS);
	hold = 1'b0;
	run_cycles(1500);

	// crc burst, long enough to wrap the counters
	phase = 2;
	run_cycles(1000);

	// lane 0 loses its SYNC words, then recovers
	phase = 3;
	wait_flag("sync lock loss", 1, 1'b0);
	check_flag("all_word_locked", all_word_locked, 1'b1);
	phase = 4;
	wait_flag("sync lock recovery", 1, 1'b1);
	wait_drain();

	for (int i = 0; i < NL; i++) begin
		check_count($sformatf("crc_err_cnt[%0d]", i), crc_err_cnt[i],
			8'(exp_flat[i][ERR_CRC32]));
		for (int k = 0; k < 4; k++) begin
			if (ev_sat[i][k]) begin
				if (ev_sum[i][k] > int'(exp_flat[i][k])) begin
					fail_now($sformatf("lane %0d kind %0d reported more than sent", i, k));
				end
			end else begin
				check_total($sformatf("event sum lane %0d kind %0d", i, k), ev_sum[i][k],
					int'(exp_flat[i][k]));
			end
		end
	end
	if (int'(exp_flat[NL-1][ERR_CRC32]) <= 256) begin
		fail_now("crc burst on the slowest lane did not pass 256 errors");
	end else begin
		$display("Simulation finished: PASS");
		$finish;
	end
end

endmodule

`default_nettype wire

// File: ilk_rx_status_properties.sv
//////////////////////////////////////////////////////////////////////
// assertions on the event credit handshake and the reset values
// bound into the reporter and the top level from the testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_rx_status_properties
	import ilk_status_pkg::*;
(
	input logic          common_clk,
	input logic          common_arst,
	input logic          ev_credit,
	input logic          ev_valid,
	input status_event_t ev,
	input logic          all_word_locked,
	input logic          all_sync_locked
);

// one spare bit so an over-return shows up
localparam int CW = $clog2(`ILK_EVENT_CREDITS + 2);

// credits the reporter may still spend, followed from the handshake alone
logic [CW-1:0] cred_model;

always_ff @(posedge common_clk or posedge common_arst) begin
	if (common_arst) begin
		cred_model <= CW'(`ILK_EVENT_CREDITS);
	end else begin
		cred_model <= cred_model - CW'(ev_valid) + CW'(ev_credit);
	end
end

// no record without a credit in hand
a_no_credit: assert property (@(posedge common_clk) disable iff (common_arst)
	ev_valid |-> (cred_model != '0))
	else $error("ev_valid high with no credits");

// the host never hands back more than it was sent
a_credit_max: assert property (@(posedge common_clk) disable iff (common_arst)
	cred_model <= `ILK_EVENT_CREDITS)
	else $error("credit count above its limit");

a_ev_known: assert property (@(posedge common_clk) disable iff (common_arst)
	ev_valid |-> !$isunknown(ev))
	else $error("unknown event record while ev_valid is high");

// first cycle out of reset
a_reset_low: assert property (@(posedge common_clk)
	$fell(common_arst) |-> (!ev_valid && !all_word_locked && !all_sync_locked))
	else $error("outputs not low after reset");

endmodule

`default_nettype wire

// File: ilk_rx_status_top.sv
//////////////////////////////////////////////////////////////////////
// rx lane status top, one framer per lane feeding the status monitor
// the event reporter sends error records to the host under credits
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_rx_status_top
	import ilk_status_pkg::*;
(
	input  logic                                          common_clk,
	input  logic                                          common_arst,
	input  logic [`ILK_NUM_LANES-1:0]                     lane_clk,
	input  logic [`ILK_NUM_LANES-1:0]                     lane_arst,
	input  lane_word_t [`ILK_NUM_LANES-1:0]               lane_in,
	input  logic                                          ev_credit,
	output logic                                          ev_valid,
	output status_event_t                                 ev,
	output logic                                          all_word_locked,
	output logic                                          all_sync_locked,
	output logic [`ILK_NUM_LANES-1:0][`ILK_CRC_CNT_W-1:0] crc_err_cnt
);

// framer status in each lane domain
lane_status_t [`ILK_NUM_LANES-1:0] lane_stat;
// same status after the crossing
lane_status_t [`ILK_NUM_LANES-1:0] sync_stat;

for (genvar i = 0; i < `ILK_NUM_LANES; i++) begin : g_framer
	ilk_lane_framer framer0 (
		.lane_clk  (lane_clk[i]),
		.lane_arst (lane_arst[i]),
		.lane_in   (lane_in[i]),
		.lane_stat (lane_stat[i])
	);
end

ilk_lane_status_monitor #(
	.SYNC_STAGES (3)
) monitor0 (
	.common_clk      (common_clk),
	.common_arst     (common_arst),
	.lane_clk        (lane_clk),
	.lane_arst       (lane_arst),
	.lane_stat       (lane_stat),
	.sync_stat       (sync_stat),
	.all_word_locked (all_word_locked),
	.all_sync_locked (all_sync_locked),
	.crc_err_cnt     (crc_err_cnt)
);

ilk_status_event_reporter reporter0 (
	.common_clk  (common_clk),
	.common_arst (common_arst),
	.sync_stat   (sync_stat),
	.ev_credit   (ev_credit),
	.ev_valid    (ev_valid),
	.ev          (ev)
);

endmodule

`default_nettype wire

// File: ilk_status_event_reporter.sv
//////////////////////////////////////////////////////////////////////
// turns synchronized error pulses into event records for the host
// pending counts per lane and kind, round robin, credit flow control
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_status_event_reporter
	import ilk_status_pkg::*;
(
	input  logic                              common_clk,
	input  logic                              common_arst,
	input  lane_status_t [`ILK_NUM_LANES-1:0] sync_stat,
	input  logic                              ev_credit,
	output logic                              ev_valid,
	output status_event_t                     ev
);

// one entry per lane and kind, index is {lane, kind}
localparam int NUM_ENT = `ILK_NUM_LANES * 4;
localparam int IDX_W = $clog2(NUM_ENT);
localparam int CRED_W = $clog2(`ILK_EVENT_CREDITS + 1);

logic [NUM_ENT-1:0] err_vec;
logic [NUM_ENT-1:0][3:0] pend_cnt;
logic [IDX_W-1:0] rr_ptr;
logic [IDX_W-1:0] sel_idx;
logic sel_found;
logic [CRED_W-1:0] credits;

// flatten the error pulses into entry order
always_comb begin
	for (int l = 0; l < `ILK_NUM_LANES; l++) begin
		err_vec[l*4 + ERR_FRAMING] = sync_stat[l].framing_error;
		err_vec[l*4 + ERR_CRC32] = sync_stat[l].crc32_error;
		err_vec[l*4 + ERR_SCRAMBLER] = sync_stat[l].scrambler_mismatch;
		err_vec[l*4 + ERR_MISSING_SYNC] = sync_stat[l].missing_sync;
	end
end

// first non-zero entry at or after the round robin pointer
always_comb begin
	logic [IDX_W-1:0] idx;
	sel_found = 1'b0;
	sel_idx = rr_ptr;
	for (int k = 0; k < NUM_ENT; k++) begin
		idx = rr_ptr + IDX_W'(k);
		if (!sel_found && pend_cnt[idx] != '0) begin
			sel_found = 1'b1;
			sel_idx = idx;
		end
	end
end

// a record goes out only while a credit is held
assign ev_valid = sel_found && (credits != '0);
assign ev.lane = sel_idx[IDX_W-1:2];
assign ev.kind = err_kind_e'(sel_idx[1:0]);
assign ev.count = pend_cnt[sel_idx];

//////////////////////////////////////////////////////////////////////
// pending counts and pointer

always_ff @(posedge common_clk or posedge common_arst) begin
	if (common_arst) begin
		pend_cnt <= '0;
		rr_ptr <= '0;
	end else begin
		for (int e = 0; e < NUM_ENT; e++) begin
			if (ev_valid && sel_idx == IDX_W'(e)) begin
				// sent this cycle, a new pulse restarts at 1
				pend_cnt[e] <= {3'b000, err_vec[e]};
			end else if (err_vec[e] && pend_cnt[e] != 4'hf) begin
				pend_cnt[e] <= pend_cnt[e] + 1'b1;
			end
		end
		if (ev_valid) begin
			rr_ptr <= sel_idx + 1'b1;
		end
	end
end

//////////////////////////////////////////////////////////////////////
// credit counter

always_ff @(posedge common_clk or posedge common_arst) begin
	if (common_arst) begin
		credits <= CRED_W'(`ILK_EVENT_CREDITS);
	end else begin
		case ({ev_valid, ev_credit})
			2'b10: credits <= credits - 1'b1;
			// return clamped at the reset value
			2'b01: begin
				if (credits != CRED_W'(`ILK_EVENT_CREDITS)) begin
					credits <= credits + 1'b1;
				end
			end
			default: credits <= credits;
		endcase
	end
end

endmodule

`default_nettype wire

// File: ilk_lane_status_monitor.sv
//////////////////////////////////////////////////////////////////////
// brings per-lane framer status into the common clock domain
// levels go through a sync chain, pulses cross as toggles
// also forms the all-locked flags and counts crc32 errors per lane
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_lane_status_monitor
	import ilk_status_pkg::*;
#(
	// 2 or more
	parameter int SYNC_STAGES = 3
) (
	input  logic                                         common_clk,
	input  logic                                         common_arst,
	input  logic [`ILK_NUM_LANES-1:0]                    lane_clk,
	input  logic [`ILK_NUM_LANES-1:0]                    lane_arst,
	input  lane_status_t [`ILK_NUM_LANES-1:0]            lane_stat,
	output lane_status_t [`ILK_NUM_LANES-1:0]            sync_stat,
	output logic                                         all_word_locked,
	output logic                                         all_sync_locked,
	output logic [`ILK_NUM_LANES-1:0][`ILK_CRC_CNT_W-1:0] crc_err_cnt
);

// synchronized lock levels gathered across lanes
logic [`ILK_NUM_LANES-1:0] word_lk_vec;
logic [`ILK_NUM_LANES-1:0] sync_lk_vec;

for (genvar i = 0; i < `ILK_NUM_LANES; i++) begin : g_lane
	// lane side, {word_locked, sync_locked}
	logic [1:0] lvl_d;
	// lane side toggles, {framing, crc32, scrambler, missing_sync}
	logic [3:0] tgl_d;
	// common side chains, the toggle chain has one extra stage
	logic [SYNC_STAGES-1:0][1:0] lvl_c;
	logic [SYNC_STAGES:0][3:0] tgl_c;
	logic [3:0] pulse;
	logic [`ILK_CRC_CNT_W-1:0] crc_cnt;

	////////////////////////////////////////////////////////////////////
	// lane clock domain

	always_ff @(posedge lane_clk[i] or posedge lane_arst[i]) begin
		if (lane_arst[i]) begin
			lvl_d <= '0;
			tgl_d <= '0;
		end else begin
			lvl_d <= {lane_stat[i].word_locked, lane_stat[i].sync_locked};
			// each one-cycle pulse flips its toggle
			tgl_d <= tgl_d ^ {lane_stat[i].framing_error,
				lane_stat[i].crc32_error,
				lane_stat[i].scrambler_mismatch,
				lane_stat[i].missing_sync};
		end
	end

	////////////////////////////////////////////////////////////////////
	// common clock domain

	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			lvl_c <= '0;
			tgl_c <= '0;
		end else begin
			// stage 0 is the metastable one, shift toward the top
			lvl_c <= {lvl_c[SYNC_STAGES-2:0], lvl_d};
			tgl_c <= {tgl_c[SYNC_STAGES-1:0], tgl_d};
		end
	end

	// a toggle edge between the last two stages is one pulse
	assign pulse = tgl_c[SYNC_STAGES] ^ tgl_c[SYNC_STAGES-1];

	// concatenation follows the field order of lane_status_t
	assign sync_stat[i] = {lvl_c[SYNC_STAGES-1], pulse};

	assign word_lk_vec[i] = sync_stat[i].word_locked;
	assign sync_lk_vec[i] = sync_stat[i].sync_locked;

	// crc32 error tally, wraps on overflow
	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			crc_cnt <= '0;
		end else if (sync_stat[i].crc32_error) begin
			crc_cnt <= crc_cnt + 1'b1;
		end
	end

	assign crc_err_cnt[i] = crc_cnt;
end

//////////////////////////////////////////////////////////////////////
// link-wide lock flags

always_ff @(posedge common_clk or posedge common_arst) begin
	if (common_arst) begin
		all_word_locked <= 1'b0;
		all_sync_locked <= 1'b0;
	end else begin
		all_word_locked <= &word_lk_vec;
		all_sync_locked <= &sync_lk_vec;
	end
end

endmodule

`default_nettype wire

// File: ilk_lane_framer.sv
//////////////////////////////////////////////////////////////////////
// per-lane framer, word lock and metaframe sync on the lane clock
// outputs lock levels and one-cycle error pulses, all registered
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ilk_consts.svh"

module ilk_lane_framer
	import ilk_status_pkg::*;
(
	input  logic         lane_clk,
	input  logic         lane_arst,
	input  lane_word_t   lane_in,
	output lane_status_t lane_stat
);

localparam int HDR_W = $clog2(`ILK_WORD_LOCK_GOOD) + 1;
localparam int SCNT_W = $clog2(`ILK_SYNC_LOCK_GOOD) + 1;
localparam int POS_W = $clog2(`ILK_MFRAME_LEN);

// word lock machine
lock_state_e wl_state, wl_next;
logic [HDR_W-1:0] hdr_cnt, hdr_cnt_next;

// metaframe sync machine
lock_state_e sy_state, sy_next;
logic [SCNT_W-1:0] sy_cnt, sy_cnt_next;
logic [POS_W-1:0] pos, pos_next;

logic good_hdr;
logic is_sync;
logic at_bound;
logic word_lk;
logic sync_lk;
logic miss_pulse;
lane_status_t stat_next;

assign good_hdr = (lane_in.kind != BAD_HDR);
assign is_sync = (lane_in.kind == SYNC);
// position 0 is where the SYNC word of each metaframe belongs
assign at_bound = (pos == '0);
assign word_lk = (wl_state == LOCKED) || (wl_state == SLIPPING);
assign sync_lk = word_lk && ((sy_state == LOCKED) || (sy_state == SLIPPING));

//////////////////////////////////////////////////////////////////////
// word lock

always_comb begin
	wl_next = wl_state;
	hdr_cnt_next = hdr_cnt;
	if (lane_in.valid) begin
		case (wl_state)
			HUNT: begin
				if (good_hdr) begin
					wl_next = LOCKING;
					hdr_cnt_next = HDR_W'(1);
				end
			end
			LOCKING: begin
				// any bad header restarts the search
				if (!good_hdr) begin
					wl_next = HUNT;
					hdr_cnt_next = '0;
				end else if (hdr_cnt == HDR_W'(`ILK_WORD_LOCK_GOOD - 1)) begin
					wl_next = LOCKED;
					hdr_cnt_next = '0;
				end else begin
					hdr_cnt_next = hdr_cnt + 1'b1;
				end
			end
			LOCKED: begin
				if (!good_hdr) begin
					wl_next = SLIPPING;
					hdr_cnt_next = HDR_W'(1);
				end
			end
			SLIPPING: begin
				// a single good header is enough to come back
				if (good_hdr) begin
					wl_next = LOCKED;
					hdr_cnt_next = '0;
				end else if (hdr_cnt == HDR_W'(`ILK_WORD_LOCK_BAD - 1)) begin
					wl_next = HUNT;
					hdr_cnt_next = '0;
				end else begin
					hdr_cnt_next = hdr_cnt + 1'b1;
				end
			end
			default: wl_next = HUNT;
		endcase
	end
end

//////////////////////////////////////////////////////////////////////
// metaframe sync

always_comb begin
	sy_next = sy_state;
	sy_cnt_next = sy_cnt;
	pos_next = pos;
	miss_pulse = 1'b0;
	if (!word_lk) begin
		// no word lock, no point tracking the metaframe
		sy_next = HUNT;
		sy_cnt_next = '0;
		pos_next = '0;
	end else if (lane_in.valid) begin
		pos_next = (pos == POS_W'(`ILK_MFRAME_LEN - 1)) ? '0 : pos + 1'b1;
		case (sy_state)
			HUNT: begin
				// take the first SYNC as position 0
				if (is_sync) begin
					sy_next = LOCKING;
					sy_cnt_next = SCNT_W'(1);
					pos_next = POS_W'(1);
				end
			end
			LOCKING: begin
				if (at_bound) begin
					if (!is_sync) begin
						sy_next = HUNT;
						sy_cnt_next = '0;
					end else if (sy_cnt == SCNT_W'(`ILK_SYNC_LOCK_GOOD - 1)) begin
						sy_next = LOCKED;
						sy_cnt_next = '0;
					end else begin
						sy_cnt_next = sy_cnt + 1'b1;
					end
				end else if (is_sync) begin
					// SYNC off the expected spacing, realign on it
					sy_cnt_next = SCNT_W'(1);
					pos_next = POS_W'(1);
				end
			end
			LOCKED: begin
				if (at_bound && !is_sync) begin
					sy_next = SLIPPING;
					sy_cnt_next = SCNT_W'(1);
					miss_pulse = 1'b1;
				end
			end
			SLIPPING: begin
				if (at_bound) begin
					if (is_sync) begin
						sy_next = LOCKED;
						sy_cnt_next = '0;
					end else begin
						// every miss is reported, the last one too
						miss_pulse = 1'b1;
						if (sy_cnt == SCNT_W'(`ILK_SYNC_LOCK_MISS - 1)) begin
							sy_next = HUNT;
							sy_cnt_next = '0;
						end else begin
							sy_cnt_next = sy_cnt + 1'b1;
						end
					end
				end
			end
			default: sy_next = HUNT;
		endcase
	end
end

//////////////////////////////////////////////////////////////////////
// status outputs

always_comb begin
	stat_next.word_locked = (wl_next == LOCKED) || (wl_next == SLIPPING);
	// sync lock never shows without word lock
	stat_next.sync_locked = stat_next.word_locked &&
		((sy_next == LOCKED) || (sy_next == SLIPPING));
	stat_next.framing_error = lane_in.valid && word_lk && !good_hdr;
	stat_next.crc32_error = lane_in.valid && sync_lk &&
		(lane_in.kind == DIAG) && !lane_in.crc_ok;
	stat_next.scrambler_mismatch = lane_in.valid && sync_lk &&
		(lane_in.kind == SCRAM) && !lane_in.scram_ok;
	stat_next.missing_sync = miss_pulse;
end

always_ff @(posedge lane_clk or posedge lane_arst) begin
	if (lane_arst) begin
		wl_state <= HUNT;
		hdr_cnt <= '0;
		sy_state <= HUNT;
		sy_cnt <= '0;
		pos <= '0;
		lane_stat <= '0;
	end else begin
		wl_state <= wl_next;
		hdr_cnt <= hdr_cnt_next;
		sy_state <= sy_next;
		sy_cnt <= sy_cnt_next;
		pos <= pos_next;
		lane_stat <= stat_next;
	end
end

endmodule

`default_nettype wire

// File: ilk_status_pkg.sv
//////////////////////////////////////////////////////////////////////
// types shared by the framer, the status monitor and the reporter
// import with a wildcard in the module header
//////////////////////////////////////////////////////////////////////
`default_nettype none

package ilk_status_pkg;

	// block header kind of a received word, already decoded by the lane
	typedef enum logic [2:0] {
		DATA    = 3'd0,
		SYNC    = 3'd1,
		SCRAM   = 3'd2,
		SKIP    = 3'd3,
		DIAG    = 3'd4,
		BAD_HDR = 3'd5
	} word_kind_e;

	// one received word as seen by the framer
	typedef struct packed {
		logic       valid;
		word_kind_e kind;
		// crc result, only looked at on DIAG words
		logic       crc_ok;
		// scrambler state check, only looked at on SCRAM words
		logic       scram_ok;
	} lane_word_t;

	// lock levels followed by single cycle error pulses
	typedef struct packed {
		logic word_locked;
		logic sync_locked;
		logic framing_error;
		logic crc32_error;
		logic scrambler_mismatch;
		logic missing_sync;
	} lane_status_t;

	// error kind, also the low index bits of a pending entry
	typedef enum logic [1:0] {
		ERR_FRAMING      = 2'd0,
		ERR_CRC32        = 2'd1,
		ERR_SCRAMBLER    = 2'd2,
		ERR_MISSING_SYNC = 2'd3
	} err_kind_e;

	// record sent to the host, count saturates at 15
	typedef struct packed {
		logic [1:0] lane;
		err_kind_e  kind;
		logic [3:0] count;
	} status_event_t;

	// shared by the word lock and the metaframe sync machines
	typedef enum logic [1:0] {
		HUNT     = 2'd0,
		LOCKING  = 2'd1,
		LOCKED   = 2'd2,
		SLIPPING = 2'd3
	} lock_state_e;

endpackage

`default_nettype wire

// File: ilk_consts.svh
//////////////////////////////////////////////////////////////////////
// shared constants of the interlaken rx lane status block
// include wherever lane counts, lock thresholds or credits are needed
//////////////////////////////////////////////////////////////////////
`ifndef ILK_CONSTS_SVH
`define ILK_CONSTS_SVH

// number of lanes in the link
`define ILK_NUM_LANES 4

// word lock, consecutive good headers to lock and bad headers to drop
`define ILK_WORD_LOCK_GOOD 8
`define ILK_WORD_LOCK_BAD 4

// metaframe length in words, and sync lock thresholds
`define ILK_MFRAME_LEN 16
`define ILK_SYNC_LOCK_GOOD 4
`define ILK_SYNC_LOCK_MISS 4

// credits the host holds after reset
`define ILK_EVENT_CREDITS 4

// width of each per-lane crc32 error counter
`define ILK_CRC_CNT_W 8

`endif
